//--- build.f
design/l2_pkg.sv
design/l2_tag_store.sv
design/l2_data_store.sv
design/l2_plru.sv
design/l2_ctrl.sv
design/l2_cache.sv
verif/mem_model.sv
verif/tb_l2_cache.sv

//--- design/l2_cache.sv
module l2_cache #(
    parameter int index_width = 2,
    parameter int offset_width = 3,
    parameter int ways = 8,
    localparam int line_width = 32 << offset_width
) (
    input  logic                  clk,
    input  logic                  rstn,

    input  logic                  icache_req,
    input  l2_pkg::word_t         icache_addr,
    output logic                  icache_addr_ok,
    output logic                  icache_data_ok,
    output logic [line_width-1:0] icache_rdata,

    input  logic                  dcache_req,
    input  logic                  dcache_wr,
    input  l2_pkg::word_t         dcache_addr,
    input  l2_pkg::word_t         dcache_wdata,
    input  logic [3:0]            dcache_wstrb,
    output logic                  dcache_addr_ok,
    output logic                  dcache_data_ok,
    output logic [line_width-1:0] dcache_rdata,

    output logic                  mem_req_r,
    output l2_pkg::word_t         mem_addr_r,
    input  logic                  mem_addr_ok_r,
    output logic                  mem_req_w,
    output l2_pkg::word_t         mem_addr_w,
    output logic [line_width-1:0] mem_wdata,
    input  logic                  mem_addr_ok_w,
    input  logic                  mem_data_ok,
    input  logic [line_width-1:0] mem_rdata
);
    import l2_pkg::*;

    localparam int way_width = $clog2(ways);
    localparam int tag_width = 30 - index_width - offset_width;

    req_src_e                  sel_src;
    req_src_e                  held_src;
    word_t                     sel_addr;
    word_t                     held_addr;
    word_t                     ctrl_wdata;
    logic                      accept;
    logic                      respond;
    logic [ways-1:0]           hit;
    logic [ways-1:0]           valid;
    logic [ways-1:0]           way_we;
    logic                      victim_dirty;
    logic                      line_replace;
    logic                      dirty_set;
    logic                      dirty_clear;
    logic                      plru_touch;
    logic                      use_mem_line;
    logic [way_width-1:0]      victim_way;
    logic [way_width-1:0]      plru_way;
    logic [way_width-1:0]      sel_way;
    logic [index_width-1:0]    rd_index;
    logic [index_width-1:0]    held_index;
    logic [offset_width-1:0]   word_offset;
    logic [3:0]                ctrl_wstrb;
    logic [tag_width-1:0]      held_tag;
    logic [tag_width-1:0]      rd_tag;
    logic [ways*line_width-1:0] line_out;
    logic [line_width-1:0]     out_line;

    // dcache has priority over icache
    always_comb begin
        sel_src  = src_none;
        sel_addr = icache_addr;
        if (dcache_req) begin
            sel_src  = dcache_wr ? src_dwrite : src_dread;
            sel_addr = dcache_addr;
        end else if (icache_req) begin
            sel_src = src_iread;
        end
    end

    assign icache_addr_ok = accept && (sel_src == src_iread);
    assign dcache_addr_ok = accept && (sel_src inside {src_dread, src_dwrite});
    assign icache_data_ok = respond && (held_src == src_iread);
    assign dcache_data_ok = respond && (held_src inside {src_dread, src_dwrite});

    assign held_tag   = held_addr[31:offset_width+index_width+2];
    assign held_index = held_addr[offset_width+index_width+1:offset_width+2];

    // store hits return the line as it was before the merge
    assign out_line     = use_mem_line ? mem_rdata : line_out[sel_way*line_width +: line_width];
    assign icache_rdata = out_line;
    assign dcache_rdata = out_line;
    assign mem_wdata    = out_line;

    assign mem_addr_r = {held_addr[31:offset_width+2], {(offset_width+2){1'b0}}};
    assign mem_addr_w = {rd_tag, held_index, {(offset_width+2){1'b0}}};

    l2_ctrl #(.index_width(index_width), .offset_width(offset_width), .ways(ways)) u_ctrl (
        .clk(clk), .rstn(rstn),
        .sel_src(sel_src), .sel_addr(sel_addr), .sel_wdata(dcache_wdata),
        .sel_wstrb(dcache_wstrb),
        .accept(accept), .respond(respond), .held_src(held_src), .held_addr(held_addr),
        .hit(hit), .valid(valid), .victim_dirty(victim_dirty), .victim_way(victim_way),
        .rd_index(rd_index), .way_we(way_we), .line_replace(line_replace),
        .word_offset(word_offset), .wstrb(ctrl_wstrb), .wdata(ctrl_wdata),
        .dirty_set(dirty_set), .dirty_clear(dirty_clear), .plru_touch(plru_touch),
        .plru_way(plru_way), .sel_way(sel_way), .use_mem_line(use_mem_line),
        .mem_req_r(mem_req_r), .mem_addr_ok_r(mem_addr_ok_r),
        .mem_req_w(mem_req_w), .mem_addr_ok_w(mem_addr_ok_w), .mem_data_ok(mem_data_ok)
    );

    l2_tag_store #(.index_width(index_width), .offset_width(offset_width), .ways(ways)) u_tag (
        .clk(clk), .rstn(rstn), .rd_index(rd_index), .cmp_tag(held_tag),
        .way_we(way_we), .wr_tag(held_tag), .dirty_set(dirty_set), .dirty_clear(dirty_clear),
        .sel_way(sel_way), .hit(hit), .valid(valid), .dirty(victim_dirty), .rd_tag(rd_tag)
    );

    l2_data_store #(.index_width(index_width), .offset_width(offset_width), .ways(ways)) u_data (
        .clk(clk), .index(rd_index), .way_we(way_we), .line_replace(line_replace),
        .mem_line(mem_rdata), .word_offset(word_offset), .wstrb(ctrl_wstrb),
        .wdata(ctrl_wdata), .line_out(line_out)
    );

    l2_plru #(.index_width(index_width), .ways(ways)) u_plru (
        .clk(clk), .rstn(rstn), .index(rd_index), .touch(plru_touch),
        .touch_way(plru_way), .valid(valid), .victim_way(victim_way)
    );

endmodule

//--- design/l2_ctrl.sv
module l2_ctrl #(
    parameter int index_width = 2,
    parameter int offset_width = 3,
    parameter int ways = 8,
    localparam int way_width = $clog2(ways)
) (
    input  logic                    clk,
    input  logic                    rstn,

    input  l2_pkg::req_src_e        sel_src,
    input  l2_pkg::word_t           sel_addr,
    input  l2_pkg::word_t           sel_wdata,
    input  logic [3:0]              sel_wstrb,

    output logic                    accept,
    output logic                    respond,
    output l2_pkg::req_src_e        held_src,
    output l2_pkg::word_t           held_addr,

    input  logic [ways-1:0]         hit,
    input  logic [ways-1:0]         valid,
    input  logic                    victim_dirty,
    input  logic [way_width-1:0]    victim_way,

    output logic [index_width-1:0]  rd_index,
    output logic [ways-1:0]         way_we,
    output logic                    line_replace,
    output logic [offset_width-1:0] word_offset,
    output logic [3:0]              wstrb,
    output l2_pkg::word_t           wdata,
    output logic                    dirty_set,
    output logic                    dirty_clear,
    output logic                    plru_touch,
    output logic [way_width-1:0]    plru_way,
    output logic [way_width-1:0]    sel_way,
    output logic                    use_mem_line,

    output logic                    mem_req_r,
    input  logic                    mem_addr_ok_r,
    output logic                    mem_req_w,
    input  logic                    mem_addr_ok_w,
    input  logic                    mem_data_ok
);
    import l2_pkg::*;

    ctrl_state_e          state;
    ctrl_state_e          state_nx;
    word_t                held_wdata;
    logic [3:0]           held_wstrb;
    logic [way_width-1:0] victim_q;
    logic [way_width-1:0] hit_way;
    logic                 is_store;

    // request buffer
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= st_idle;
            held_src <= src_none;
        end else begin
            state <= state_nx;
            if (accept) begin
                held_src <= sel_src;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held_addr  <= sel_addr;
            held_wdata <= sel_wdata;
            held_wstrb <= sel_wstrb;
        end
        // victim stays fixed for the rest of the miss
        if (state == st_lookup) begin
            victim_q <= victim_way;
        end
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < ways; w++) begin
            if (hit[w]) begin
                hit_way = way_width'(w);
            end
        end
    end

    assign is_store    = (held_src == src_dwrite);
    assign wdata       = held_wdata;
    assign wstrb       = is_store ? held_wstrb : 4'b0000;
    assign word_offset = held_addr[offset_width+1:2];

    // arbiter index until a request is held
    assign rd_index = (state == st_idle) ?
                      sel_addr[offset_width+index_width+1:offset_width+2] :
                      held_addr[offset_width+index_width+1:offset_width+2];

    always_comb begin
        if (state == st_lookup) begin
            sel_way = (|hit) ? hit_way : victim_way;
        end else begin
            sel_way = victim_q;
        end
    end

    always_comb begin
        state_nx     = state;
        accept       = 1'b0;
        respond      = 1'b0;
        way_we       = '0;
        line_replace = 1'b0;
        dirty_set    = 1'b0;
        dirty_clear  = 1'b0;
        plru_touch   = 1'b0;
        plru_way     = hit_way;
        use_mem_line = 1'b0;
        mem_req_r    = 1'b0;
        mem_req_w    = 1'b0;
        case (state)
            st_idle: begin
                if (sel_src != src_none) begin
                    accept   = 1'b1;
                    state_nx = st_lookup;
                end
            end
            st_lookup: begin
                if (|hit) begin
                    respond    = 1'b1;
                    plru_touch = 1'b1;
                    if (is_store) begin
                        way_we    = hit;
                        dirty_set = 1'b1;
                    end
                    state_nx = st_idle;
                end else if (victim_dirty && valid[victim_way]) begin
                    state_nx = st_writeback;
                end else begin
                    state_nx = st_refill_req;
                end
            end
            st_writeback: begin
                mem_req_w = 1'b1;
                if (mem_addr_ok_w) begin
                    state_nx = st_refill_req;
                end
            end
            st_refill_req: begin
                mem_req_r = 1'b1;
                if (mem_addr_ok_r) begin
                    state_nx = st_refill_wait;
                end
            end
            st_refill_wait: begin
                use_mem_line = 1'b1;
                if (mem_data_ok) begin
                    way_we[victim_q] = 1'b1;
                    line_replace     = 1'b1;
                    // a store allocate leaves the new line dirty
                    dirty_set        = is_store;
                    dirty_clear      = !is_store;
                    plru_touch       = 1'b1;
                    plru_way         = victim_q;
                    state_nx         = st_respond;
                end
            end
            st_respond: begin
                respond  = 1'b1;
                state_nx = st_idle;
            end
            default: begin
                state_nx = st_idle;
            end
        endcase
    end

endmodule

//--- design/l2_data_store.sv
module l2_data_store #(
    parameter int index_width = 2,
    parameter int offset_width = 3,
    parameter int ways = 8,
    localparam int line_width = 32 << offset_width
) (
    input  logic                        clk,
    input  logic [index_width-1:0]      index,
    input  logic [ways-1:0]             way_we,
    input  logic                        line_replace,
    input  logic [line_width-1:0]       mem_line,
    input  logic [offset_width-1:0]     word_offset,
    input  logic [3:0]                  wstrb,
    input  l2_pkg::word_t               wdata,
    output logic [ways*line_width-1:0]  line_out
);
    localparam int sets = 1 << index_width;

    logic [line_width-1:0] line_mem [sets][ways];
    logic [line_width-1:0] new_line [ways];

    // base line, then the store bytes on top
    always_comb begin
        for (int w = 0; w < ways; w++) begin
            new_line[w] = line_replace ? mem_line : line_out[w*line_width +: line_width];
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) begin
                    new_line[w][(word_offset*4 + b)*8 +: 8] = wdata[b*8 +: 8];
                end
            end
        end
    end

    // written way reads back its new contents at the same edge
    always_ff @(posedge clk) begin
        for (int w = 0; w < ways; w++) begin
            if (way_we[w]) begin
                line_mem[index][w] <= new_line[w];
            end
            line_out[w*line_width +: line_width] <= way_we[w] ? new_line[w] :
                                                    line_mem[index][w];
        end
    end

endmodule

//--- design/l2_pkg.sv
package l2_pkg;

    // data word or byte address
    typedef logic [31:0] word_t;

    // who issued the request held in the controller
    typedef enum logic [1:0] {
        src_none   = 2'd0,
        src_iread  = 2'd1,
        src_dread  = 2'd2,
        src_dwrite = 2'd3
    } req_src_e;

    typedef enum logic [2:0] {
        st_idle        = 3'd0,
        st_lookup      = 3'd1,
        st_writeback   = 3'd2,
        st_refill_req  = 3'd3,
        st_refill_wait = 3'd4,
        st_respond     = 3'd5
    } ctrl_state_e;

endpackage

//--- design/l2_plru.sv
module l2_plru #(
    parameter int index_width = 2,
    parameter int ways = 8,
    localparam int way_width = $clog2(ways)
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [index_width-1:0] index,
    input  logic                   touch,
    input  logic [way_width-1:0]   touch_way,
    input  logic [ways-1:0]        valid,
    output logic [way_width-1:0]   victim_way
);
    localparam int sets = 1 << index_width;

    // heap order, node 1 is the root, 1 means go right
    logic [ways-1:1] tree [sets];
    logic [ways-1:1] tree_nx;

    always_comb begin : pick_victim
        int   node;
        logic found;
        node = 1;
        for (int l = 0; l < way_width; l++) begin
            node = 2 * node + int'(tree[index][node]);
        end
        victim_way = way_width'(node - ways);
        found = 1'b0;
        for (int w = 0; w < ways; w++) begin
            if (!valid[w] && !found) begin
                victim_way = way_width'(w);
                found      = 1'b1;
            end
        end
    end

    // point every node on the path away from the used way
    always_comb begin : path_update
        int node;
        tree_nx = tree[index];
        node = 1;
        for (int l = 0; l < way_width; l++) begin
            tree_nx[node] = ~touch_way[way_width-1-l];
            node = 2 * node + int'(touch_way[way_width-1-l]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < sets; s++) begin
                tree[s] <= '0;
            end
        end else if (touch) begin
            tree[index] <= tree_nx;
        end
    end

endmodule

//--- design/l2_tag_store.sv
module l2_tag_store #(
    parameter int index_width = 2,
    parameter int offset_width = 3,
    parameter int ways = 8,
    localparam int way_width = $clog2(ways),
    localparam int tag_width = 30 - index_width - offset_width
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [index_width-1:0] rd_index,
    input  logic [tag_width-1:0]   cmp_tag,
    input  logic [ways-1:0]        way_we,
    input  logic [tag_width-1:0]   wr_tag,
    input  logic                   dirty_set,
    input  logic                   dirty_clear,
    input  logic [way_width-1:0]   sel_way,
    output logic [ways-1:0]        hit,
    output logic [ways-1:0]        valid,
    output logic                   dirty,
    output logic [tag_width-1:0]   rd_tag
);
    localparam int sets = 1 << index_width;

    logic [tag_width-1:0] tag_mem [sets][ways];
    logic [ways-1:0]      valid_mem [sets];
    logic [ways-1:0]      dirty_mem [sets];
    logic [tag_width-1:0] tag_q [ways];
    logic [ways-1:0]      valid_q;
    logic [ways-1:0]      dirty_q;

    always_ff @(posedge clk) begin
        for (int w = 0; w < ways; w++) begin
            if (way_we[w]) begin
                tag_mem[rd_index][w] <= wr_tag;
            end
            tag_q[w] <= tag_mem[rd_index][w];
        end
    end

    // state bits cleared in place, no init walk
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < sets; s++) begin
                valid_mem[s] <= '0;
                dirty_mem[s] <= '0;
            end
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            valid_q <= valid_mem[rd_index];
            dirty_q <= dirty_mem[rd_index];
            for (int w = 0; w < ways; w++) begin
                if (way_we[w]) begin
                    valid_mem[rd_index][w] <= 1'b1;
                    if (dirty_set) begin
                        dirty_mem[rd_index][w] <= 1'b1;
                    end else if (dirty_clear) begin
                        dirty_mem[rd_index][w] <= 1'b0;
                    end
                end
            end
        end
    end

    always_comb begin
        for (int w = 0; w < ways; w++) begin
            hit[w] = valid_q[w] && (tag_q[w] == cmp_tag);
        end
    end

    assign valid  = valid_q;
    assign dirty  = dirty_q[sel_way];
    assign rd_tag = tag_q[sel_way];

endmodule

//--- verif/mem_model.sv
module mem_model #(
    parameter int offset_width = 3,
    localparam int line_width = 32 << offset_width
) (
    input  logic                  clk,
    input  logic                  mem_req_r,
    input  l2_pkg::word_t         mem_addr_r,
    output logic                  mem_addr_ok_r,
    input  logic                  mem_req_w,
    input  l2_pkg::word_t         mem_addr_w,
    input  logic [line_width-1:0] mem_wdata,
    output logic                  mem_addr_ok_w,
    output logic                  mem_data_ok,
    output logic [line_width-1:0] mem_rdata
);
    timeunit 1ns;
    timeprecision 100ps;
    import l2_pkg::*;

    localparam int words = 1 << offset_width;

    word_t  store [word_t];
    word_t  rd_addr;
    integer seed = 86318;
    int     rd_wait = -1;
    int     wr_wait = -1;
    int     data_wait = -1;

    // untouched memory reads back a pattern of its own address
    function automatic word_t base_word(word_t addr);
        return addr ^ 32'h5a3c_96e1;
    endfunction

    initial begin
        mem_addr_ok_r = 1'b0;
        mem_addr_ok_w = 1'b0;
        mem_data_ok   = 1'b0;
        mem_rdata     = '0;
    end

    // bus outputs change on the falling edge only
    always @(negedge clk) begin : bus_side
        word_t key;
        mem_addr_ok_r = 1'b0;
        mem_addr_ok_w = 1'b0;
        mem_data_ok   = 1'b0;
        if (data_wait == 0) begin
            for (int i = 0; i < words; i++) begin
                key = rd_addr + 4 * i;
                mem_rdata[i*32 +: 32] = store.exists(key) ? store[key] : base_word(key);
            end
            mem_data_ok = 1'b1;
        end
        if (data_wait >= 0) begin
            data_wait--;
        end
        if (mem_req_r) begin
            if (rd_wait < 0) begin
                rd_wait = $unsigned($random(seed)) % 6;
            end
            if (rd_wait == 0) begin
                mem_addr_ok_r = 1'b1;
                rd_addr       = mem_addr_r;
                data_wait     = $unsigned($random(seed)) % 6;
            end
            rd_wait--;
        end
        // posted write, done at the accept
        if (mem_req_w) begin
            if (wr_wait < 0) begin
                wr_wait = $unsigned($random(seed)) % 6;
            end
            if (wr_wait == 0) begin
                mem_addr_ok_w = 1'b1;
                for (int i = 0; i < words; i++) begin
                    store[mem_addr_w + 4 * i] = mem_wdata[i*32 +: 32];
                end
            end
            wr_wait--;
        end
    end

endmodule

//--- verif/tb_l2_cache.sv
module tb_l2_cache;
    timeunit 1ns;
    timeprecision 100ps;
    import l2_pkg::*;

    localparam int index_width = 2;
    localparam int offset_width = 3;
    localparam int ways = 8;
    localparam int line_width = 32 << offset_width;
    localparam int words = 1 << offset_width;
    localparam int src_i = 0;
    localparam int src_d = 1;
    localparam int src_both = 2;

    typedef struct {
        int         src;
        logic       wr;
        word_t      addr;
        word_t      wdata;
        logic [3:0] wstrb;
        logic       exp_hit;
    } row_t;

    logic                  clk;
    logic                  rstn;
    logic                  icache_req;
    word_t                 icache_addr;
    logic                  icache_addr_ok;
    logic                  icache_data_ok;
    logic [line_width-1:0] icache_rdata;
    logic                  dcache_req;
    logic                  dcache_wr;
    word_t                 dcache_addr;
    word_t                 dcache_wdata;
    logic [3:0]            dcache_wstrb;
    logic                  dcache_addr_ok;
    logic                  dcache_data_ok;
    logic [line_width-1:0] dcache_rdata;
    logic                  mem_req_r;
    logic                  mem_req_w;
    logic                  mem_addr_ok_r;
    logic                  mem_addr_ok_w;
    logic                  mem_data_ok;
    word_t                 mem_addr_r;
    word_t                 mem_addr_w;
    logic [line_width-1:0] mem_wdata;
    logic [line_width-1:0] mem_rdata;

    row_t  rows[$];
    word_t shadow [word_t];
    word_t req_line;
    int    limit_cycles = 0;

    l2_cache #(.index_width(index_width), .offset_width(offset_width), .ways(ways)) dut (.*);

    mem_model #(.offset_width(offset_width)) u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic word_t base_word(word_t addr);
        return addr ^ 32'h5a3c_96e1;
    endfunction

    function automatic word_t line_addr(int tag, int set, int word);
        return word_t'((tag << (offset_width + index_width + 2)) |
                       (set << (offset_width + 2)) | (word << 2));
    endfunction

    // latest contents of a line as the L1 side wrote it
    function automatic logic [line_width-1:0] shadow_line(word_t addr);
        word_t                 key;
        logic [line_width-1:0] data;
        for (int i = 0; i < words; i++) begin
            key = {addr[31:offset_width+2], {(offset_width+2){1'b0}}} + 4 * i;
            data[i*32 +: 32] = shadow.exists(key) ? shadow[key] : base_word(key);
        end
        return data;
    endfunction

    task automatic apply_store(word_t addr, word_t wdata, logic [3:0] wstrb);
        word_t key;
        word_t w;
        key = {addr[31:2], 2'b00};
        w = shadow.exists(key) ? shadow[key] : base_word(key);
        for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) begin
                w[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        shadow[key] = w;
    endtask

    task automatic report_mismatch(string name, logic [line_width-1:0] expected,
                                   logic [line_width-1:0] actual);
        $display("[ERROR] %0t %s expected %h got %h", $time, name, expected, actual);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic abort_run(string reason);
        $display("%0t %s", $time, reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic add_row(int src, logic wr, word_t addr, word_t wdata, logic [3:0] wstrb,
                           logic exp_hit);
        row_t r;
        r = '{src, wr, addr, wdata, wstrb, exp_hit};
        rows.push_back(r);
    endtask

    // drives one row at the falling edge, samples at the rising edge
    task automatic run_row(row_t r);
        logic [line_width-1:0] exp_i;
        logic [line_width-1:0] pre_d;
        logic [line_width-1:0] post_d;
        logic                  da;
        logic                  ia;
        logic                  dd;
        logic                  id;
        logic                  i_done;
        logic                  d_done;
        logic                  d_acc;
        logic                  refilled;
        int                    cycle;
        int                    acc_cycle;
        i_done = (r.src == src_d);
        d_done = (r.src == src_i);
        d_acc = 1'b0;
        refilled = 1'b0;
        cycle = 0;
        acc_cycle = 0;
        req_line = {r.addr[31:offset_width+2], {(offset_width+2){1'b0}}};
        icache_req   = !i_done;
        icache_addr  = r.addr;
        dcache_req   = !d_done;
        dcache_wr    = r.wr;
        dcache_addr  = r.addr;
        dcache_wdata = r.wdata;
        dcache_wstrb = r.wstrb;
        while (!(i_done && d_done)) begin
            @(posedge clk);
            cycle++;
            da = dcache_addr_ok;
            ia = icache_addr_ok;
            dd = dcache_data_ok;
            id = icache_data_ok;
            refilled |= mem_req_r;
            if (da) begin
                pre_d = shadow_line(r.addr);
                if (r.wr) begin
                    apply_store(r.addr, r.wdata, r.wstrb);
                end
                post_d = shadow_line(r.addr);
                d_acc = 1'b1;
                refilled = 1'b0;
                acc_cycle = cycle;
            end
            if (ia) begin
                assert (d_acc || r.src == src_i)
                else abort_run("icache was accepted ahead of a pending dcache request");
                exp_i = shadow_line(r.addr);
                refilled = 1'b0;
                acc_cycle = cycle;
            end
            // a store hit answers with the line from before the merge
            if (dd) begin
                assert (dcache_rdata == (r.exp_hit ? pre_d : post_d))
                else report_mismatch("dcache_rdata", r.exp_hit ? pre_d : post_d, dcache_rdata);
                d_done = 1'b1;
            end
            if (id) begin
                assert (icache_rdata == exp_i)
                else report_mismatch("icache_rdata", exp_i, icache_rdata);
                i_done = 1'b1;
            end
            if ((dd || id) && r.exp_hit) begin
                assert (cycle - acc_cycle == 1 && !refilled)
                else abort_run("a row marked as a hit took extra cycles or a memory refill");
            end
            @(negedge clk);
            if (da) begin
                dcache_req = 1'b0;
            end
            if (ia) begin
                icache_req = 1'b0;
            end
        end
    endtask

    always @(posedge clk) begin
        // every posted writeback must carry the newest data of its line
        if (mem_req_w && mem_addr_ok_w) begin
            assert (mem_wdata == shadow_line(mem_addr_w))
            else report_mismatch("mem_wdata", shadow_line(mem_addr_w), mem_wdata);
        end
        // refill fetches the aligned line of the request in flight
        if (mem_req_r && mem_addr_ok_r) begin
            assert (mem_addr_r == req_line)
            else report_mismatch("mem_addr_r", req_line, mem_addr_r);
        end
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        abort_run("watchdog expired before all rows completed");
    end

    initial begin
        rstn = 1'b0;
        icache_req = 1'b0;
        icache_addr = '0;
        dcache_req = 1'b0;
        dcache_wr = 1'b0;
        dcache_addr = '0;
        dcache_wdata = '0;
        dcache_wstrb = '0;
        add_row(src_d, 0, line_addr(1, 0, 0), 0, 4'b0000, 0);
        add_row(src_d, 0, line_addr(1, 0, 3), 0, 4'b0000, 1);
        add_row(src_i, 0, line_addr(2, 2, 1), 0, 4'b0000, 0);
        add_row(src_i, 0, line_addr(2, 2, 5), 0, 4'b0000, 1);
        // store allocate, read back, store hit
        add_row(src_d, 1, line_addr(3, 3, 2), 32'ha5a5_1234, 4'b0011, 0);
        add_row(src_d, 0, line_addr(3, 3, 2), 0, 4'b0000, 1);
        add_row(src_d, 1, line_addr(3, 3, 2), 32'hdead_beef, 4'b1100, 1);
        add_row(src_d, 0, line_addr(3, 3, 6), 0, 4'b0000, 1);
        add_row(src_both, 0, line_addr(4, 0, 1), 0, 4'b0000, 0);
        // nine tags in one set overflow eight ways
        for (int t = 0; t < 9; t++) begin
            add_row(src_d, 1, line_addr(16 + t, 1, t % words), 32'h1000_0000 + t * 32'h0101_0101,
                    (t % 2) ? 4'b0110 : 4'b1111, 0);
        end
        for (int t = 0; t < 9; t++) begin
            add_row(src_d, 0, line_addr(16 + t, 1, 0), 0, 4'b0000, 0);
        end
        add_row(src_i, 0, line_addr(24, 1, 4), 0, 4'b0000, 1);
        add_row(src_both, 1, line_addr(5, 1, 7), 32'h0bad_cafe, 4'b1001, 0);
        add_row(src_d, 0, line_addr(16, 1, 0), 0, 4'b0000, 0);
        limit_cycles = rows.size() * 60 + 10;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        @(posedge clk);
        assert (!icache_addr_ok && !dcache_addr_ok && !icache_data_ok && !dcache_data_ok &&
                !mem_req_r && !mem_req_w)
        else abort_run("a handshake or memory request was high right after reset");
        @(negedge clk);
        foreach (rows[n]) begin
            run_row(rows[n]);
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule
